// ==== hockey_params.svh ====
// Field size, timing and segment constants for the air hockey RTL and its testbench
`ifndef HOCKEY_PARAMS_SVH
`define HOCKEY_PARAMS_SVH

// Field size
`define HOCKEY_COLS 5
`define HOCKEY_ROWS 5

// Clock cycles per step time
// Set to 200000000 for a 2 s step on the board
`define HOCKEY_STEP_TICKS 8

// Clock cycles per blink phase on the end screen
`define HOCKEY_BLINK_TICKS 6

`define HOCKEY_WIN_SCORE 3

// Active-low abcdefg segment patterns
`define SEG_0 7'b0000001
`define SEG_1 7'b1001111
`define SEG_2 7'b0010010
`define SEG_3 7'b0000110
`define SEG_4 7'b1001100
`define SEG_A 7'b0001000
`define SEG_B 7'b1100000
`define SEG_DASH 7'b1111110
`define SEG_BLANK 7'b1111111

`endif

// ==== hockey_pkg.sv ====
// Game state and puck direction types shared by the controller, puck, display and testbench
package hockey_pkg;

    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        SHOW_SCORE = 4'd1,
        SERVE_A    = 4'd2,
        SERVE_B    = 4'd3,
        TRAVEL_A   = 4'd4,   // Heading toward A's edge
        TRAVEL_B   = 4'd5,
        RECEIVE_A  = 4'd6,
        RECEIVE_B  = 4'd7,
        GOAL_A     = 4'd8,   // A scored
        GOAL_B     = 4'd9,
        GAME_OVER  = 4'd10
    } game_state_t;

    // Value 3 is not named and moves straight
    typedef enum logic [1:0] {
        STRAIGHT = 2'd0,
        DOWN     = 2'd1,     // Row increasing
        UP       = 2'd2
    } puck_dir_t;

endpackage

// ==== puck_motion.sv ====
// Puck position and heading registers, driven by serve, return and step pulses from game_ctrl
`timescale 1ns/1ps
`include "hockey_params.svh"

module puck_motion (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  serve_a,
    input  logic                  serve_b,
    input  logic                  return_a,
    input  logic                  return_b,
    input  logic                  step,
    input  logic [2:0]            launch_row,
    input  hockey_pkg::puck_dir_t launch_dir,
    output logic [2:0]            puck_col,
    output logic [2:0]            puck_row,
    output logic                  at_edge
);

    hockey_pkg::puck_dir_t dir;
    hockey_pkg::puck_dir_t src_dir;
    hockey_pkg::puck_dir_t next_dir;
    logic [2:0]            next_row;
    logic                  toward_b;   // Column increasing

    // A return takes the returning player's direction
    assign src_dir = (return_a || return_b) ? launch_dir : dir;

    // Row step with bounce off the top and bottom rows
    always_comb
    begin
        next_row = puck_row;
        next_dir = hockey_pkg::STRAIGHT;
        case (src_dir)
            hockey_pkg::DOWN:
            begin
                if (puck_row == 3'(`HOCKEY_ROWS - 1))
                begin
                    next_row = puck_row - 3'd1;
                    next_dir = hockey_pkg::UP;
                end
                else
                begin
                    next_row = puck_row + 3'd1;
                    next_dir = hockey_pkg::DOWN;
                end
            end
            hockey_pkg::UP:
            begin
                if (puck_row == 3'd0)
                begin
                    next_row = puck_row + 3'd1;
                    next_dir = hockey_pkg::DOWN;
                end
                else
                begin
                    next_row = puck_row - 3'd1;
                    next_dir = hockey_pkg::UP;
                end
            end
            default:
            begin
                next_row = puck_row;   // Straight, also the unused code 3
                next_dir = hockey_pkg::STRAIGHT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            puck_col <= 3'd0;
            puck_row <= 3'd0;
            dir      <= hockey_pkg::STRAIGHT;
            toward_b <= 1'b1;
        end
        else if (serve_a || serve_b)
        begin
            puck_col <= serve_a ? 3'd0 : 3'(`HOCKEY_COLS - 1);
            puck_row <= launch_row;
            dir      <= launch_dir;
            toward_b <= serve_a;
        end
        else if (return_a || return_b)
        begin
            puck_col <= return_a ? 3'd1 : 3'(`HOCKEY_COLS - 2);
            puck_row <= next_row;
            dir      <= next_dir;
            toward_b <= return_a;
        end
        else if (step)
        begin
            puck_col <= toward_b ? puck_col + 3'd1 : puck_col - 3'd1;
            puck_row <= next_row;
            dir      <= next_dir;
        end
    end

    assign at_edge = toward_b ? (puck_col == 3'(`HOCKEY_COLS - 1)) : (puck_col == 3'd0);

    assert property (@(posedge clk) disable iff (rst)
        (puck_col < 3'(`HOCKEY_COLS)) && (puck_row < 3'(`HOCKEY_ROWS)))
        else $error("puck left the field: col %0d row %0d", puck_col, puck_row);

endmodule

// ==== game_ctrl.sv ====
// Game sequencer: start, serve, travel, receive window, goals, end screen and score keeping
`timescale 1ns/1ps
`include "hockey_params.svh"

module game_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    btn_a,
    input  logic                    btn_b,
    input  logic [1:0]              dir_a,
    input  logic [1:0]              dir_b,
    input  logic [2:0]              row_a,
    input  logic [2:0]              row_b,
    input  logic [2:0]              puck_row,
    input  logic                    at_edge,
    output hockey_pkg::game_state_t state,
    output logic [1:0]              score_a,
    output logic [1:0]              score_b,
    output logic                    blink,
    output logic                    serve_a,
    output logic                    serve_b,
    output logic                    return_a,
    output logic                    return_b,
    output logic                    step,
    output logic [2:0]              launch_row,
    output hockey_pkg::puck_dir_t   launch_dir
);

    localparam int TICK_MAX = (`HOCKEY_STEP_TICKS > `HOCKEY_BLINK_TICKS) ?
                              `HOCKEY_STEP_TICKS : `HOCKEY_BLINK_TICKS;
    localparam int TIMER_W  = $clog2(TICK_MAX);

    logic [TIMER_W-1:0] timer;
    logic               step_done;
    logic               blink_done;
    logic               timer_run;
    logic               first_a;     // A serves after the score screen
    logic [2:0]         hops_left;   // Steps until the puck reaches the far edge

    assign step_done  = (timer == TIMER_W'(`HOCKEY_STEP_TICKS - 1));
    assign blink_done = (timer == TIMER_W'(`HOCKEY_BLINK_TICKS - 1));
    assign timer_run  = state inside {hockey_pkg::SHOW_SCORE, hockey_pkg::TRAVEL_A,
                                      hockey_pkg::TRAVEL_B, hockey_pkg::RECEIVE_A,
                                      hockey_pkg::RECEIVE_B, hockey_pkg::GOAL_A,
                                      hockey_pkg::GOAL_B};

    // Puck pulses, same cycle as the press or timer wrap
    assign serve_a  = (state == hockey_pkg::SERVE_A) && btn_a && (row_a < 3'(`HOCKEY_ROWS));
    assign serve_b  = (state == hockey_pkg::SERVE_B) && btn_b && (row_b < 3'(`HOCKEY_ROWS));
    assign return_a = (state == hockey_pkg::RECEIVE_A) && btn_a && (row_a == puck_row);
    assign return_b = (state == hockey_pkg::RECEIVE_B) && btn_b && (row_b == puck_row);
    assign step     = ((state == hockey_pkg::TRAVEL_A) || (state == hockey_pkg::TRAVEL_B))
                      && step_done;

    assign launch_row = (state == hockey_pkg::SERVE_B) ? row_b : row_a;
    assign launch_dir = hockey_pkg::puck_dir_t'(((state == hockey_pkg::SERVE_B) ||
                                                 (state == hockey_pkg::RECEIVE_B)) ?
                                                dir_b : dir_a);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            timer <= '0;
        else if (state == hockey_pkg::GAME_OVER)
            timer <= blink_done ? '0 : timer + 1'b1;
        else if (timer_run && !step_done && !return_a && !return_b)
            timer <= timer + 1'b1;
        else
            timer <= '0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= hockey_pkg::IDLE;
            score_a   <= 2'd0;
            score_b   <= 2'd0;
            blink     <= 1'b0;
            first_a   <= 1'b1;
            hops_left <= 3'd0;
        end
        else
        begin
            case (state)
                hockey_pkg::IDLE:
                begin
                    if (btn_a || btn_b)
                    begin
                        first_a <= btn_a;   // A wins a tie
                        state   <= hockey_pkg::SHOW_SCORE;
                    end
                end
                hockey_pkg::SHOW_SCORE:
                begin
                    if (step_done)
                        state <= first_a ? hockey_pkg::SERVE_A : hockey_pkg::SERVE_B;
                end
                hockey_pkg::SERVE_A, hockey_pkg::SERVE_B:
                begin
                    if (serve_a || serve_b)
                    begin
                        hops_left <= 3'(`HOCKEY_COLS - 1);
                        state     <= serve_a ? hockey_pkg::TRAVEL_B : hockey_pkg::TRAVEL_A;
                    end
                end
                hockey_pkg::TRAVEL_A, hockey_pkg::TRAVEL_B:
                begin
                    if (step)
                    begin
                        hops_left <= hops_left - 3'd1;
                        if (hops_left == 3'd1)
                            state <= (state == hockey_pkg::TRAVEL_A) ?
                                     hockey_pkg::RECEIVE_A : hockey_pkg::RECEIVE_B;
                    end
                end
                hockey_pkg::RECEIVE_A:
                begin
                    if (return_a)
                    begin
                        hops_left <= 3'(`HOCKEY_COLS - 2);
                        state     <= hockey_pkg::TRAVEL_B;
                    end
                    else if (step_done)
                    begin
                        score_b <= score_b + 2'd1;
                        state   <= hockey_pkg::GOAL_B;
                    end
                end
                hockey_pkg::RECEIVE_B:
                begin
                    if (return_b)
                    begin
                        hops_left <= 3'(`HOCKEY_COLS - 2);
                        state     <= hockey_pkg::TRAVEL_A;
                    end
                    else if (step_done)
                    begin
                        score_a <= score_a + 2'd1;
                        state   <= hockey_pkg::GOAL_A;
                    end
                end
                hockey_pkg::GOAL_A:
                begin
                    if (step_done)
                        state <= (score_a == 2'(`HOCKEY_WIN_SCORE)) ?
                                 hockey_pkg::GAME_OVER : hockey_pkg::SERVE_B;
                end
                hockey_pkg::GOAL_B:
                begin
                    if (step_done)
                        state <= (score_b == 2'(`HOCKEY_WIN_SCORE)) ?
                                 hockey_pkg::GAME_OVER : hockey_pkg::SERVE_A;
                end
                hockey_pkg::GAME_OVER:
                begin
                    if (blink_done)
                        blink <= ~blink;
                end
                default: state <= hockey_pkg::IDLE;
            endcase
        end
    end

    // No play after a winning score
    assert property (@(posedge clk) disable iff (rst)
        ((score_a == 2'(`HOCKEY_WIN_SCORE)) || (score_b == 2'(`HOCKEY_WIN_SCORE))) |->
        (state inside {hockey_pkg::GOAL_A, hockey_pkg::GOAL_B, hockey_pkg::GAME_OVER}))
        else $error("play continued at a winning score: %0d-%0d", score_a, score_b);

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({serve_a, serve_b, return_a, return_b, step}))
        else $error("more than one puck pulse in a cycle");

    // The puck sits on the receiver's edge for the whole window
    assert property (@(posedge clk) disable iff (rst)
        (state inside {hockey_pkg::RECEIVE_A, hockey_pkg::RECEIVE_B}) |-> at_edge)
        else $error("receive window without the puck at the edge");

endmodule

// ==== hockey_display.sv ====
// Combinational decode of game state, scores and puck into seven-segment digits and LEDs
`timescale 1ns/1ps
`include "hockey_params.svh"

module hockey_display (
    input  hockey_pkg::game_state_t state,
    input  logic [1:0]              score_a,
    input  logic [1:0]              score_b,
    input  logic                    blink,
    input  logic [2:0]              puck_col,
    input  logic [2:0]              puck_row,
    input  logic [2:0]              row_a,
    input  logic [2:0]              row_b,
    output logic                    led_a,
    output logic                    led_b,
    output logic [4:0]              led_x,
    output logic [6:0]              ssd0,
    output logic [6:0]              ssd1,
    output logic [6:0]              ssd2,
    output logic [6:0]              ssd4
);

    logic [6:0] seg_score_a;
    logic [6:0] seg_score_b;
    logic       a_wins;

    // Rows 5 to 7 show a dash
    function automatic logic [6:0] seg_digit(input logic [2:0] value);
        case (value)
            3'd0:    seg_digit = `SEG_0;
            3'd1:    seg_digit = `SEG_1;
            3'd2:    seg_digit = `SEG_2;
            3'd3:    seg_digit = `SEG_3;
            3'd4:    seg_digit = `SEG_4;
            default: seg_digit = `SEG_DASH;
        endcase
    endfunction

    assign seg_score_a = seg_digit({1'b0, score_a});
    assign seg_score_b = seg_digit({1'b0, score_b});
    assign a_wins      = (score_a > score_b);

    always_comb
    begin
        ssd0  = `SEG_BLANK;
        ssd1  = `SEG_BLANK;
        ssd2  = `SEG_BLANK;
        ssd4  = `SEG_BLANK;
        led_a = 1'b0;
        led_b = 1'b0;
        led_x = 5'b00000;
        case (state)
            hockey_pkg::IDLE:
            begin
                ssd2  = `SEG_A;   // "A-b"
                ssd1  = `SEG_DASH;
                ssd0  = `SEG_B;
                led_a = 1'b1;
                led_b = 1'b1;
            end
            hockey_pkg::SHOW_SCORE, hockey_pkg::GOAL_A, hockey_pkg::GOAL_B:
            begin
                ssd2  = seg_score_a;
                ssd1  = `SEG_DASH;
                ssd0  = seg_score_b;
                led_x = 5'b11111;
            end
            hockey_pkg::SERVE_A:
            begin
                ssd4  = seg_digit(row_a);   // Live row choice
                led_a = 1'b1;
            end
            hockey_pkg::SERVE_B:
            begin
                ssd4  = seg_digit(row_b);
                led_b = 1'b1;
            end
            hockey_pkg::TRAVEL_A, hockey_pkg::TRAVEL_B:
            begin
                ssd4  = seg_digit(puck_row);
                led_x = 5'b10000 >> puck_col;   // Column 0 on the MSB
            end
            hockey_pkg::RECEIVE_A:
            begin
                ssd4  = seg_digit(puck_row);
                led_a = 1'b1;
                led_x = 5'b10000;
            end
            hockey_pkg::RECEIVE_B:
            begin
                ssd4  = seg_digit(puck_row);
                led_b = 1'b1;
                led_x = 5'b00001;
            end
            hockey_pkg::GAME_OVER:
            begin
                ssd2  = seg_score_a;
                ssd1  = `SEG_DASH;
                ssd0  = seg_score_b;
                ssd4  = a_wins ? `SEG_A : `SEG_B;
                led_a = a_wins;
                led_b = !a_wins;
                led_x = blink ? 5'b10101 : 5'b01010;
            end
            default: led_x = 5'b00000;
        endcase
    end

endmodule

// ==== hockey.sv ====
// Top level of the air hockey game, joining the controller, puck registers and display
`timescale 1ns/1ps
`include "hockey_params.svh"

module hockey (
    input  logic       clk,
    input  logic       rst,
    input  logic       btn_a,
    input  logic       btn_b,
    input  logic [1:0] dir_a,
    input  logic [1:0] dir_b,
    input  logic [2:0] row_a,
    input  logic [2:0] row_b,
    output logic       led_a,
    output logic       led_b,
    output logic [4:0] led_x,
    output logic [6:0] ssd0,
    output logic [6:0] ssd1,
    output logic [6:0] ssd2,
    output logic [6:0] ssd4
);

    hockey_pkg::game_state_t state;
    hockey_pkg::puck_dir_t   launch_dir;
    logic [1:0]              score_a;
    logic [1:0]              score_b;
    logic                    blink;
    logic                    serve_a;
    logic                    serve_b;
    logic                    return_a;
    logic                    return_b;
    logic                    step;
    logic [2:0]              launch_row;
    logic [2:0]              puck_col;
    logic [2:0]              puck_row;
    logic                    at_edge;

    game_ctrl game_ctrl_i (.*);

    puck_motion puck_motion_i (.*);

    hockey_display hockey_display_i (.*);

endmodule

// ==== tb_hockey.sv ====
// Self-checking testbench for the air hockey top level with LFSR-driven players and a cycle model
`timescale 1ns/1ps
`include "hockey_params.svh"

module tb_hockey;

    localparam int STEP       = `HOCKEY_STEP_TICKS;
    localparam int BLINK      = `HOCKEY_BLINK_TICKS;
    localparam int WIN        = `HOCKEY_WIN_SCORE;
    localparam int GAMES      = 12;
    localparam int MAX_CYCLES = GAMES * 40 * STEP * 2;   // 40 steps per game, doubled

    logic       clk;
    logic       rst;
    logic       btn_a;
    logic       btn_b;
    logic [1:0] dir_a;
    logic [1:0] dir_b;
    logic [2:0] row_a;
    logic [2:0] row_b;
    logic       led_a;
    logic       led_b;
    logic [4:0] led_x;
    logic [6:0] ssd0;
    logic [6:0] ssd1;
    logic [6:0] ssd2;
    logic [6:0] ssd4;

    hockey_pkg::game_state_t m_state;   // Reference model
    int         m_cnt;                  // Cycles since the last state change or step
    logic [1:0] m_score_a;
    logic [1:0] m_score_b;
    logic       m_blink;
    logic [2:0] m_col;
    logic [2:0] m_row;
    logic [1:0] m_dir;
    logic       m_toward_b;
    logic       m_first_a;

    logic       exp_led_a;
    logic       exp_led_b;
    logic [4:0] exp_led_x;
    logic [6:0] exp_ssd0;
    logic [6:0] exp_ssd1;
    logic [6:0] exp_ssd2;
    logic [6:0] exp_ssd4;

    logic [31:0] lfsr_state = 32'hbfe5;
    logic        hit_plan;
    logic [1:0]  press_at;
    logic        skip_press;
    int          cycles = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          returns = 0;
    int          goals = 0;
    int          bounces = 0;
    int          bad_serves = 0;

    hockey hockey_i (.*);

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic int take_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // Returns {direction, row} after one row step
    function automatic logic [4:0] bounce(input logic [2:0] row, input logic [1:0] dir);
        if (dir == 2'd1)
            return (row == 3'd4) ? {2'd2, 3'd3} : {2'd1, row + 3'd1};
        else if (dir == 2'd2)
            return (row == 3'd0) ? {2'd1, 3'd1} : {2'd2, row - 3'd1};
        return {2'd0, row};
    endfunction

    function automatic logic [6:0] digit_pattern(input int value);
        case (value)
            0:       return `SEG_0;
            1:       return `SEG_1;
            2:       return `SEG_2;
            3:       return `SEG_3;
            4:       return `SEG_4;
            default: return `SEG_DASH;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [6:0] got,
                                   input logic [6:0] expected);
        mismatches++;
        $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, expected);
    endtask

    task automatic print_summary();
        $display("Summary: %0d mismatches, %0d other errors, %0d cycles",
                 mismatches, other_errors, cycles);
    endtask

    task automatic apply_reset();
        btn_a = 1'b0;
        btn_b = 1'b0;
        rst   = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic drive_player(input logic is_a, input logic btn, input logic [2:0] row,
                                input logic [1:0] dir);
        if (is_a)
        begin
            btn_a = btn;
            row_a = row;
            dir_a = dir;
        end
        else
        begin
            btn_b = btn;
            row_b = row;
            dir_b = dir;
        end
    endtask

    // Inputs for the next rising edge, chosen from the model state
    task automatic play_cycle();
        logic       is_a;
        logic [2:0] row;
        logic [1:0] new_dir;
        logic       press;
        int         wrong;
        btn_a = 1'b0;
        btn_b = 1'b0;
        is_a  = (m_state == hockey_pkg::SERVE_A) || (m_state == hockey_pkg::RECEIVE_A);
        if (m_state inside {hockey_pkg::SERVE_A, hockey_pkg::SERVE_B})
        begin
            row     = 3'(take_bits(3));   // Rows 5 to 7 included
            new_dir = 2'(take_bits(2));
            press   = (take_bits(1) == 1);
            drive_player(is_a, press, row, new_dir);
        end
        else if (m_state inside {hockey_pkg::RECEIVE_A, hockey_pkg::RECEIVE_B})
        begin
            if (m_cnt == 0)
            begin
                hit_plan   = (take_bits(1) == 1);
                press_at   = 2'(take_bits(2));
                skip_press = (take_bits(1) == 1);
            end
            if (m_cnt == int'(press_at))
            begin
                wrong   = take_bits(2);
                new_dir = 2'(take_bits(2));
                row     = hit_plan ? m_row : 3'((int'(m_row) + 1 + wrong) % 5);
                drive_player(is_a, hit_plan || !skip_press, row, new_dir);
            end
        end
    endtask

    task automatic check_coverage();
        if (returns == 0 || goals == 0)
        begin
            $display("The players never produced both a return and a goal");
            other_errors++;
        end
        if (bounces == 0 || bad_serves == 0)
        begin
            $display("No wall bounce or no serve press with an invalid row was seen");
            other_errors++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk or posedge rst)
    begin
        logic [4:0] moved;
        logic [2:0] next_col;
        logic       act_a;
        logic       p_btn;
        logic [2:0] p_row;
        logic [1:0] p_dir;
        act_a = (m_state == hockey_pkg::SERVE_A) || (m_state == hockey_pkg::RECEIVE_A);
        p_btn = act_a ? btn_a : btn_b;
        p_row = act_a ? row_a : row_b;
        p_dir = act_a ? dir_a : dir_b;
        if (rst)
        begin
            m_state    <= hockey_pkg::IDLE;
            m_cnt      <= 0;
            m_score_a  <= 2'd0;
            m_score_b  <= 2'd0;
            m_blink    <= 1'b0;
            m_col      <= 3'd0;
            m_row      <= 3'd0;
            m_dir      <= 2'd0;
            m_toward_b <= 1'b1;
            m_first_a  <= 1'b1;
        end
        else
        begin
            m_cnt <= m_cnt + 1;
            case (m_state)
                hockey_pkg::IDLE:
                    if (btn_a || btn_b)
                    begin
                        m_first_a <= btn_a;
                        m_state   <= hockey_pkg::SHOW_SCORE;
                        m_cnt     <= 0;
                    end
                hockey_pkg::SHOW_SCORE:
                    if (m_cnt == STEP - 1)
                    begin
                        m_state <= m_first_a ? hockey_pkg::SERVE_A : hockey_pkg::SERVE_B;
                        m_cnt   <= 0;
                    end
                hockey_pkg::SERVE_A, hockey_pkg::SERVE_B:
                begin
                    if (p_btn && p_row >= 3'd5)
                        bad_serves <= bad_serves + 1;
                    if (p_btn && p_row < 3'd5)
                    begin
                        m_col      <= act_a ? 3'd0 : 3'd4;
                        m_row      <= p_row;
                        m_dir      <= p_dir;
                        m_toward_b <= act_a;
                        m_state    <= act_a ? hockey_pkg::TRAVEL_B : hockey_pkg::TRAVEL_A;
                        m_cnt      <= 0;
                    end
                end
                hockey_pkg::TRAVEL_A, hockey_pkg::TRAVEL_B:
                    if (m_cnt == STEP - 1)
                    begin
                        next_col = m_toward_b ? m_col + 3'd1 : m_col - 3'd1;
                        moved    = bounce(m_row, m_dir);
                        if ((m_dir == 2'd1 && m_row == 3'd4) || (m_dir == 2'd2 && m_row == 3'd0))
                            bounces <= bounces + 1;
                        m_col <= next_col;
                        m_row <= moved[2:0];
                        m_dir <= moved[4:3];
                        m_cnt <= 0;
                        if (next_col == (m_toward_b ? 3'd4 : 3'd0))
                            m_state <= m_toward_b ? hockey_pkg::RECEIVE_B : hockey_pkg::RECEIVE_A;
                    end
                hockey_pkg::RECEIVE_A, hockey_pkg::RECEIVE_B:
                begin
                    if (p_btn && p_row == m_row)
                    begin
                        moved = bounce(m_row, p_dir);   // Returner's own direction
                        m_row      <= moved[2:0];
                        m_dir      <= moved[4:3];
                        m_col      <= act_a ? 3'd1 : 3'd3;
                        m_toward_b <= act_a;
                        m_state    <= act_a ? hockey_pkg::TRAVEL_B : hockey_pkg::TRAVEL_A;
                        m_cnt      <= 0;
                        returns    <= returns + 1;
                    end
                    else if (m_cnt == STEP - 1)
                    begin
                        if (act_a)
                            m_score_b <= m_score_b + 2'd1;
                        else
                            m_score_a <= m_score_a + 2'd1;
                        m_state <= act_a ? hockey_pkg::GOAL_B : hockey_pkg::GOAL_A;
                        m_cnt   <= 0;
                        goals   <= goals + 1;
                    end
                end
                hockey_pkg::GOAL_A, hockey_pkg::GOAL_B:
                    if (m_cnt == STEP - 1)
                    begin
                        m_cnt <= 0;
                        if (int'(m_score_a) == WIN || int'(m_score_b) == WIN)
                            m_state <= hockey_pkg::GAME_OVER;
                        else if (m_state == hockey_pkg::GOAL_A)
                            m_state <= hockey_pkg::SERVE_B;   // Conceder serves
                        else
                            m_state <= hockey_pkg::SERVE_A;
                    end
                default:
                    if (m_cnt == BLINK - 1)
                    begin
                        m_blink <= ~m_blink;
                        m_cnt   <= 0;
                    end
            endcase
        end
    end

    always_comb
    begin
        exp_ssd0  = `SEG_BLANK;
        exp_ssd1  = `SEG_BLANK;
        exp_ssd2  = `SEG_BLANK;
        exp_ssd4  = `SEG_BLANK;
        exp_led_a = 1'b0;
        exp_led_b = 1'b0;
        exp_led_x = 5'b00000;
        if (m_state inside {hockey_pkg::SHOW_SCORE, hockey_pkg::GOAL_A, hockey_pkg::GOAL_B,
                            hockey_pkg::GAME_OVER})
        begin
            exp_ssd2  = digit_pattern(int'(m_score_a));
            exp_ssd1  = `SEG_DASH;
            exp_ssd0  = digit_pattern(int'(m_score_b));
            exp_led_x = 5'b11111;
        end
        case (m_state)
            hockey_pkg::IDLE:
            begin
                exp_ssd2  = `SEG_A;
                exp_ssd1  = `SEG_DASH;
                exp_ssd0  = `SEG_B;
                exp_led_a = 1'b1;
                exp_led_b = 1'b1;
            end
            hockey_pkg::SERVE_A:
            begin
                exp_ssd4  = digit_pattern(int'(row_a));
                exp_led_a = 1'b1;
            end
            hockey_pkg::SERVE_B:
            begin
                exp_ssd4  = digit_pattern(int'(row_b));
                exp_led_b = 1'b1;
            end
            hockey_pkg::TRAVEL_A, hockey_pkg::TRAVEL_B:
            begin
                exp_ssd4 = digit_pattern(int'(m_row));
                exp_led_x[4 - int'(m_col)] = 1'b1;
            end
            hockey_pkg::RECEIVE_A, hockey_pkg::RECEIVE_B:
            begin
                exp_ssd4  = digit_pattern(int'(m_row));
                exp_led_a = (m_state == hockey_pkg::RECEIVE_A);
                exp_led_b = (m_state == hockey_pkg::RECEIVE_B);
                exp_led_x = exp_led_a ? 5'b10000 : 5'b00001;
            end
            hockey_pkg::GAME_OVER:
            begin
                exp_led_a = (int'(m_score_a) == WIN);
                exp_led_b = !exp_led_a;
                exp_ssd4  = exp_led_a ? `SEG_A : `SEG_B;
                exp_led_x = m_blink ? 5'b10101 : 5'b01010;
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) led_a == exp_led_a)
        else report_mismatch("led_a", 7'($sampled(led_a)), 7'($sampled(exp_led_a)));
    assert property (@(posedge clk) disable iff (rst) led_b == exp_led_b)
        else report_mismatch("led_b", 7'($sampled(led_b)), 7'($sampled(exp_led_b)));
    assert property (@(posedge clk) disable iff (rst) led_x == exp_led_x)
        else report_mismatch("led_x", 7'($sampled(led_x)), 7'($sampled(exp_led_x)));
    assert property (@(posedge clk) disable iff (rst) ssd0 == exp_ssd0)
        else report_mismatch("ssd0", $sampled(ssd0), $sampled(exp_ssd0));
    assert property (@(posedge clk) disable iff (rst) ssd1 == exp_ssd1)
        else report_mismatch("ssd1", $sampled(ssd1), $sampled(exp_ssd1));
    assert property (@(posedge clk) disable iff (rst) ssd2 == exp_ssd2)
        else report_mismatch("ssd2", $sampled(ssd2), $sampled(exp_ssd2));
    assert property (@(posedge clk) disable iff (rst) ssd4 == exp_ssd4)
        else report_mismatch("ssd4", $sampled(ssd4), $sampled(exp_ssd4));

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
        begin
            $display("Timeout: the games were still running after %0d cycles", MAX_CYCLES);
            other_errors = other_errors + 1;
            print_summary();
            $display("Something failed");
            $finish;
        end
    end

    initial
    begin
        rst   = 1'b1;
        btn_a = 1'b0;
        btn_b = 1'b0;
        dir_a = 2'd0;
        dir_b = 2'd0;
        row_a = 3'd0;
        row_b = 3'd0;
        for (int game = 0; game < GAMES; game++)
        begin
            apply_reset();
            repeat (2 + take_bits(3)) @(negedge clk);   // Idle screen holds
            case (take_bits(2))
                0:
                begin
                    btn_a = 1'b1;   // Both at once
                    btn_b = 1'b1;
                end
                1:       btn_a = 1'b1;
                default: btn_b = 1'b1;
            endcase
            @(negedge clk);
            while (m_state != hockey_pkg::GAME_OVER)
            begin
                play_cycle();
                @(negedge clk);
            end
            btn_a = 1'b0;
            btn_b = 1'b0;
            repeat (4 * BLINK + 2) @(negedge clk);
        end
        check_coverage();
        print_summary();
        if (mismatches == 0 && other_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
hockey_pkg.sv
puck_motion.sv
game_ctrl.sv
hockey_display.sv
hockey.sv
tb_hockey.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_hockey -o tb_hockey \
    && ./obj_dir/tb_hockey | tee /dev/stderr | grep -q "Everything OK" \
    && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
